/* sim/forth_cpu_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module forth_cpu_assert (
    input wire logic                clk,
    input wire logic                nreset,
    input wire cpu_core_pkg::word_t mem_addr,
    input wire cpu_core_pkg::word_t mem_wdata,
    input wire logic                mem_valid,
    input wire logic                mem_nwr,
    input wire logic                mem_ready,
    input wire logic                hlt,
    input wire logic                error
);

    int violations = 0; // Read by the testbench for its closing count.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data bus handshake.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    property p_hold_request;
        @(posedge clk) disable iff (!nreset)
            (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr)
                && $stable(mem_wdata) && $stable(mem_nwr));
    endproperty

    a_hold_request : assert property (p_hold_request)
        else begin
            $error("Bus request changed while mem_ready was low.");
            violations++;
        end

    a_idle_when_stopped : assert property (
        @(posedge clk) disable iff (!nreset) (hlt || error) |-> !mem_valid)
        else begin
            $error("Bus request seen after the core stopped.");
            violations++;
        end

    a_idle_after_reset : assert property (@(posedge clk) $rose(nreset) |-> !mem_valid)
        else begin
            $error("mem_valid high in the first cycle after reset.");
            violations++;
        end

endmodule

bind forth_cpu forth_cpu_assert u_assert (
    .clk       (clk),
    .nreset    (nreset),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_valid (mem_valid),
    .mem_nwr   (mem_nwr),
    .mem_ready (mem_ready),
    .hlt       (hlt),
    .error     (error)
);

`default_nettype wire

/* sim/forth_cpu_golden.txt */
# T <test id> | P <program bytes in hex, appended> | M <word addr> <initial words, 4 hex each>
# E <word addr> <expected words, 4 hex each> | F <final status, 1 for hlt, 2 for error>
# ALU codes F0 to FC on 9C35 and 0A23, then sub, compares and shr on 0005 and 8000.
T 1
P 00359C00230A1010F0001000021010F1001100021010F2001200021010F300130002
P 1010F4001400021010F5001500021010F6001600021010F7001700021010F800180002
P 1010F9001900021010FA001A00021010FB001B00021010FC001C0002
P 0D0D0005000000801010F1002100021010F5002200021010F600230002
P 1010F7002400021010F8002500021010F9002600021010FA002700021010FC0028000208
E 0010 A658921208219E379616000000010001000100000000E1A81386
E 0021 80050000000100000000000100010005
F 1
# dup, swap, over and drop, each followed by a store.
T 2
P 0011110022220033330100400002 0E004100021000420002
P 0D004444004300020044000200555500666 60E10004500020046000200470002 08
E 0040 33332222111144441111666655556666
F 1
# br and br0 taken and not taken, jmp, and nested call and ret.
T 3
P 0001000A0D0000AAAA005000020000000A4900003412005100020000000B2700
P 00BBBB005200020005000B490000785600530002033E0000CCCC0054000205510000BC9A00570002
P 0800ADDE005F00020800111100550002056300003333005600020600222200550002 06
M 0050 70007001700270037004700570067007
M 005F 700F
E 0050 70001234700256787004222233339ABC
E 005F 700F
F 1
# get through random wait states, results modified and written back.
T 4
P 00600004000001F0007000020061000400620004F400710002
P 0062000400720002006000040001 00F10060000208
M 0060 1357F0F00FF0
E 0060 1356F0F00FF0
E 0070 1457FF000FF0
F 1
# hlt stops the core before the second store.
T 5
P 000100008000020800020000810002
M 0080 80008001
E 0080 00018001
F 1
# The dropped multiply code FD raises error after the first store.
T 6
P 00040000900002000300000500FD0091000208
M 0090 90009001
E 0090 00049001
F 2

/* sim/tb_forth_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_forth_cpu;
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int RUN_LIMIT    = 5000; // Cycles allowed for one program.
    localparam int DRAIN_CYCLES = 4;

    logic       clk;
    logic       nreset;
    code_addr_t rom_addr;
    opcode_t    rom_data;
    word_t      mem_addr;
    word_t      mem_wdata;
    word_t      mem_rdata;
    logic       mem_valid;
    logic       mem_nwr;
    logic       mem_ready;
    logic       hlt;
    logic       error;

    opcode_t     rom [1 << CODE_ADDR_BITS];
    word_t       dmem [256];
    logic [7:0]  exp_addr [$];
    word_t       exp_word [$];
    int          prog_len;
    int          test_id;
    int          checks;
    int          errors;
    logic [31:0] rnd_state = 32'd19056;
    logic        busy;
    int          delay_left;
    logic        pend_write;
    word_t       pend_addr;
    word_t       pend_wdata;

    forth_cpu u_dut (
        .clk       (clk),
        .nreset    (nreset),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid),
        .mem_nwr   (mem_nwr),
        .mem_ready (mem_ready),
        .hlt       (hlt),
        .error     (error)
    );

    assign rom_data = rom[rom_addr]; // Program memory answers in the same cycle.

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Error: test %0d %s is %h, expected %h", test_id, name, got, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data memory with 0 to 3 random wait states before each ready.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        busy       = 1'b0;
        delay_left = 0;
        pend_write = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!nreset) begin
                mem_ready  = 1'b0;
                busy       = 1'b0;
                pend_write = 1'b0;
            end else if (mem_ready) begin
                if (pend_write) begin
                    dmem[pend_addr[7:0]] = pend_wdata; // The handshake edge has passed.
                end
                mem_ready  = 1'b0;
                pend_write = 1'b0;
            end else if (mem_valid) begin
                if (!busy) begin
                    busy       = 1'b1;
                    rnd_state  = xorshift(rnd_state);
                    delay_left = int'(rnd_state % 4);
                end
                if (delay_left == 0) begin
                    mem_ready  = 1'b1;
                    mem_rdata  = dmem[mem_addr[7:0]];
                    pend_write = !mem_nwr;
                    pend_addr  = mem_addr;
                    pend_wdata = mem_wdata;
                    busy       = 1'b0;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    task automatic clear_test();
        int i;
        for (i = 0; i < (1 << CODE_ADDR_BITS); i++) begin
            rom[i] = opcode_t'(8'hFD + i % 3); // FD to FF are all illegal.
        end
        for (i = 0; i < 256; i++) begin
            dmem[i] = 16'hB000 ^ word_t'(i * 37);
        end
        exp_addr.delete();
        exp_word.delete();
        prog_len = 0;
    endtask

    // Hex digits pair up into bytes across any spaces in the record.
    task automatic append_program(input string text);
        int    i;
        string hex;
        hex = "";
        for (i = 0; i < text.len(); i++) begin
            if ((text[i] >= "0" && text[i] <= "9") || (text[i] >= "a" && text[i] <= "f")
                    || (text[i] >= "A" && text[i] <= "F")) begin
                hex = {hex, text.substr(i, i)};
            end
        end
        for (i = 0; i < hex.len() / 2; i++) begin
            rom[prog_len] = opcode_t'(hex.substr(2 * i, 2 * i + 1).atohex());
            prog_len++;
        end
    endtask

    task automatic record_words(input int addr, input string hex, input bit expected);
        int    i;
        word_t w;
        for (i = 0; i < hex.len() / 4; i++) begin
            w = word_t'(hex.substr(4 * i, 4 * i + 3).atohex());
            if (expected) begin
                exp_addr.push_back(8'(addr + i));
                exp_word.push_back(w);
            end else begin
                dmem[8'(addr + i)] = w;
            end
        end
    endtask

    task automatic run_test(input int status);
        int cycles;
        int i;
        nreset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        compare_value("mem_valid", mem_valid, 16'h0);
        compare_value("mem_nwr", mem_nwr, 16'h1);
        compare_value("hlt", hlt, 16'h0);
        compare_value("error", error, 16'h0);
        compare_value("rom_addr", rom_addr, 16'h0);
        nreset = 1'b1;
        cycles = 0;
        while (!(hlt === 1'b1 || error === 1'b1) && cycles < RUN_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (hlt === 1'b1 || error === 1'b1) else begin
            errors++;
            $display("Test %0d did not stop within %0d cycles.", test_id, RUN_LIMIT);
        end
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            #1;
            compare_value("mem_valid", mem_valid, 16'h0); // Stopped core stays off the bus.
        end
        compare_value("hlt", hlt, 16'(status == 1));
        compare_value("error", error, 16'(status == 2));
        for (i = 0; i < exp_addr.size(); i++) begin
            compare_value($sformatf("dmem[%h]", exp_addr[i]), dmem[exp_addr[i]], exp_word[i]);
        end
    endtask

    initial begin
        string line;
        string kind;
        string data;
        int    fd;
        int    addr;
        int    status;
        clk     = 1'b0;
        nreset  = 1'b0;
        errors  = 0;
        checks  = 0;
        test_id = 0;
        clear_test();
        fd = $fopen("sim/forth_cpu_golden.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("Cannot open sim/forth_cpu_golden.txt for reading.");
        end
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                kind = "";
                void'($sscanf(line, "%s", kind));
                case (kind)
                    "T": begin
                        void'($sscanf(line, "%s %d", kind, test_id));
                        clear_test();
                    end
                    "P": begin
                        append_program(line.substr(1, line.len() - 1));
                    end
                    "M", "E": begin
                        void'($sscanf(line, "%s %h %s", kind, addr, data));
                        record_words(addr, data, kind == "E");
                    end
                    "F": begin
                        void'($sscanf(line, "%s %d", kind, status));
                        run_test(status);
                    end
                    default: begin
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("Checks: %0d, value errors: %0d, bus assertion errors: %0d",
                 checks, errors, u_dut.u_assert.violations);
        if (errors == 0 && u_dut.u_assert.violations == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/cpu_isa_pkg.sv
verilog/cpu_core_pkg.sv
verilog/stack_if.sv
verilog/op_decoder.sv
verilog/stack_alu.sv
verilog/stack_ram.sv
verilog/sequencer.sv
verilog/forth_cpu.sv
sim/forth_cpu_assert.sv
sim/tb_forth_cpu.sv

/* verilog/cpu_core_pkg.sv */
`default_nettype none

package cpu_core_pkg;

    localparam int WORD_BITS      = 16;
    localparam int CODE_ADDR_BITS = 12;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [CODE_ADDR_BITS-1:0] code_addr_t; // Byte address into program memory.

    localparam int DSTACK_DEPTH = 64;
    localparam int RSTACK_DEPTH = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stack commands, applied at the next rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        STK_NONE,
        STK_PUSH,
        STK_POP,
        STK_POP2,
        STK_POP_REPLACE, // Drop the top and overwrite the word below it.
        STK_SWAP
    } stack_cmd_t;

    typedef enum logic [2:0] {
        ST_EXEC,
        ST_IMM_LO,
        ST_IMM_HI,
        ST_BUS_WAIT,
        ST_HALTED,
        ST_FAILED
    } seq_state_t;

endpackage

`default_nettype wire

/* verilog/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

    typedef logic [7:0] opcode_t;

    localparam opcode_t OP_PUSH = 8'd0;
    localparam opcode_t OP_DUP  = 8'd1;
    localparam opcode_t OP_SET  = 8'd2;
    localparam opcode_t OP_JMP  = 8'd3;
    localparam opcode_t OP_GET  = 8'd4;
    localparam opcode_t OP_CALL = 8'd5;
    localparam opcode_t OP_RET  = 8'd6;
    localparam opcode_t OP_HLT  = 8'd8;
    localparam opcode_t OP_BR   = 8'd10;
    localparam opcode_t OP_BR0  = 8'd11;
    localparam opcode_t OP_DROP = 8'd13;
    localparam opcode_t OP_SWAP = 8'd14;
    localparam opcode_t OP_OVER = 8'd16;

    localparam logic [3:0] ALU_PREFIX = 4'hF; // High nibble of every ALU opcode.
    localparam logic [3:0] ALU_LAST   = 4'd12;

    // Left operand is the word below the top, right operand the top.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_EQ, ALU_NE, ALU_GT, ALU_GE, ALU_LE, ALU_LT,
        ALU_SHL, ALU_SHR
    } alu_op_t;

    typedef enum logic [3:0] {
        CLS_LIT, CLS_DUP, CLS_DROP, CLS_SWAP, CLS_OVER, CLS_ALU,
        CLS_JUMP, CLS_CALL, CLS_RET, CLS_BR, CLS_BR0,
        CLS_GET, CLS_SET, CLS_HALT, CLS_ILLEGAL
    } op_class_t;

    typedef struct packed {
        op_class_t op_class;
        alu_op_t   alu_op;
    } decoded_t;

endpackage

`default_nettype wire

/* verilog/forth_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module forth_cpu (
    input  wire logic                     clk,
    input  wire logic                     nreset,
    output wire cpu_core_pkg::code_addr_t rom_addr,
    input  wire cpu_isa_pkg::opcode_t     rom_data,
    output wire cpu_core_pkg::word_t      mem_addr,
    output wire cpu_core_pkg::word_t      mem_wdata,
    input  wire cpu_core_pkg::word_t      mem_rdata,
    output wire logic                     mem_valid,
    output wire logic                     mem_nwr,
    input  wire logic                     mem_ready,
    output wire logic                     hlt,
    output wire logic                     error
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    decoded_t decoded;
    word_t    alu_result;

    stack_if #(.entry_t(word_t))      dstack_bus ();
    stack_if #(.entry_t(code_addr_t)) rstack_bus ();

    op_decoder u_decoder (
        .opcode  (rom_data),
        .decoded (decoded)
    );

    stack_alu u_alu (
        .operands (dstack_bus.peek),
        .op       (decoded.alu_op),
        .result   (alu_result)
    );

    stack_ram #(.entry_t(word_t), .DEPTH(DSTACK_DEPTH)) u_dstack (
        .clk    (clk),
        .nreset (nreset),
        .port   (dstack_bus)
    );

    stack_ram #(.entry_t(code_addr_t), .DEPTH(RSTACK_DEPTH)) u_rstack (
        .clk    (clk),
        .nreset (nreset),
        .port   (rstack_bus)
    );

    sequencer u_seq (
        .clk        (clk),
        .nreset     (nreset),
        .decoded    (decoded),
        .alu_result (alu_result),
        .rom_data   (rom_data),
        .rom_addr   (rom_addr),
        .dstack     (dstack_bus),
        .rstack     (rstack_bus),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_valid  (mem_valid),
        .mem_nwr    (mem_nwr),
        .mem_ready  (mem_ready),
        .hlt        (hlt),
        .error      (error)
    );

endmodule

`default_nettype wire

/* verilog/op_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module op_decoder (
    input  wire cpu_isa_pkg::opcode_t opcode,
    output cpu_isa_pkg::decoded_t     decoded
);
    import cpu_isa_pkg::*;

    always_comb begin
        decoded.alu_op = alu_op_t'(opcode[3:0]); // Only meaningful for the ALU class.
        case (opcode)
            OP_PUSH: decoded.op_class = CLS_LIT;
            OP_DUP:  decoded.op_class = CLS_DUP;
            OP_SET:  decoded.op_class = CLS_SET;
            OP_JMP:  decoded.op_class = CLS_JUMP;
            OP_GET:  decoded.op_class = CLS_GET;
            OP_CALL: decoded.op_class = CLS_CALL;
            OP_RET:  decoded.op_class = CLS_RET;
            OP_HLT:  decoded.op_class = CLS_HALT;
            OP_BR:   decoded.op_class = CLS_BR;
            OP_BR0:  decoded.op_class = CLS_BR0;
            OP_DROP: decoded.op_class = CLS_DROP;
            OP_SWAP: decoded.op_class = CLS_SWAP;
            OP_OVER: decoded.op_class = CLS_OVER;
            default: begin
                // Codes 0xFD to 0xFF were multiply and divide and are not built.
                if (opcode[7:4] == ALU_PREFIX && opcode[3:0] <= ALU_LAST) begin
                    decoded.op_class = CLS_ALU;
                end else begin
                    decoded.op_class = CLS_ILLEGAL;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module sequencer (
    input  wire logic                    clk,
    input  wire logic                    nreset,
    input  wire cpu_isa_pkg::decoded_t   decoded,
    input  wire cpu_core_pkg::word_t     alu_result,
    input  wire cpu_isa_pkg::opcode_t    rom_data,
    output cpu_core_pkg::code_addr_t     rom_addr,
    stack_if.owner                       dstack,
    stack_if.owner                       rstack,
    output cpu_core_pkg::word_t          mem_addr,
    output cpu_core_pkg::word_t          mem_wdata,
    input  wire cpu_core_pkg::word_t     mem_rdata,
    output logic                         mem_valid,
    output logic                         mem_nwr,
    input  wire logic                    mem_ready,
    output logic                         hlt,
    output logic                         error
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    seq_state_t state;
    code_addr_t pc;
    code_addr_t pc_inc;
    op_class_t  cur_class;  // Class of the instruction whose immediate is being read.
    opcode_t    imm_lo;
    logic       taken;
    word_t      imm_word;
    code_addr_t imm_target;

    assign pc_inc     = pc + 1'b1;
    assign imm_word   = {rom_data, imm_lo};
    assign imm_target = imm_word[CODE_ADDR_BITS-1:0];
    assign rom_addr   = pc;

    assign hlt   = state == ST_HALTED;
    assign error = state == ST_FAILED;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stack commands for the current cycle.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        dstack.cmd     = STK_NONE;
        dstack.wr_data = dstack.top;
        rstack.cmd     = STK_NONE;
        rstack.wr_data = pc_inc; // Return address, first byte after the call.
        case (state)
            ST_EXEC: begin
                case (decoded.op_class)
                    CLS_DUP: begin
                        dstack.cmd = STK_PUSH;
                    end
                    CLS_OVER: begin
                        dstack.cmd     = STK_PUSH;
                        dstack.wr_data = dstack.next;
                    end
                    CLS_DROP, CLS_BR, CLS_BR0, CLS_GET: begin
                        dstack.cmd = STK_POP;
                    end
                    CLS_SWAP: begin
                        dstack.cmd = STK_SWAP;
                    end
                    CLS_ALU: begin
                        dstack.cmd     = STK_POP_REPLACE;
                        dstack.wr_data = alu_result;
                    end
                    CLS_SET: begin
                        dstack.cmd = STK_POP2;
                    end
                    CLS_RET: begin
                        rstack.cmd = STK_POP;
                    end
                    default: begin
                    end
                endcase
            end
            ST_IMM_HI: begin
                if (cur_class == CLS_LIT) begin
                    dstack.cmd     = STK_PUSH;
                    dstack.wr_data = imm_word;
                end
                if (cur_class == CLS_CALL) begin
                    rstack.cmd = STK_PUSH;
                end
            end
            ST_BUS_WAIT: begin
                // The address was popped on issue, the loaded word goes back in its place.
                if (mem_ready && cur_class == CLS_GET) begin
                    dstack.cmd     = STK_PUSH;
                    dstack.wr_data = mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!nreset) begin
            state     <= ST_EXEC;
            pc        <= '0;
            mem_valid <= 1'b0;
            mem_nwr   <= 1'b1;
        end else begin
            case (state)
                ST_EXEC: begin
                    pc <= pc_inc;
                    case (decoded.op_class)
                        CLS_LIT, CLS_JUMP, CLS_CALL, CLS_BR, CLS_BR0: begin
                            state <= ST_IMM_LO;
                        end
                        CLS_RET: begin
                            pc <= rstack.top;
                        end
                        CLS_GET, CLS_SET: begin
                            mem_valid <= 1'b1;
                            mem_nwr   <= decoded.op_class != CLS_SET;
                            state     <= ST_BUS_WAIT;
                        end
                        CLS_HALT: begin
                            pc    <= pc;
                            state <= ST_HALTED;
                        end
                        CLS_ILLEGAL: begin
                            pc    <= pc;
                            state <= ST_FAILED;
                        end
                        default: begin
                        end
                    endcase
                end
                ST_IMM_LO: begin
                    pc    <= pc_inc;
                    state <= ST_IMM_HI;
                end
                ST_IMM_HI: begin
                    state <= ST_EXEC;
                    case (cur_class)
                        CLS_JUMP, CLS_CALL: pc <= imm_target;
                        CLS_BR, CLS_BR0:    pc <= taken ? imm_target : pc_inc;
                        default:            pc <= pc_inc;
                    endcase
                end
                ST_BUS_WAIT: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        mem_nwr   <= 1'b1;
                        state     <= ST_EXEC;
                    end
                end
                default: begin
                    state <= state; // Halted and failed hold until reset.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EXEC) begin
            cur_class <= decoded.op_class;
            taken     <= (dstack.top != '0) == (decoded.op_class == CLS_BR);
            if (decoded.op_class == CLS_GET || decoded.op_class == CLS_SET) begin
                mem_addr  <= dstack.top;
                mem_wdata <= dstack.next;
            end
        end
        if (state == ST_IMM_LO) begin
            imm_lo <= rom_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/stack_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module stack_alu (
    stack_if.peek                     operands,
    input  wire cpu_isa_pkg::alu_op_t op,
    output cpu_core_pkg::word_t       result
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    word_t lhs;
    word_t rhs;

    assign lhs = operands.next;
    assign rhs = operands.top;

    // Comparisons are unsigned and give 0 or 1 in a full word.
    always_comb begin
        case (op)
            ALU_ADD: result = lhs + rhs;
            ALU_SUB: result = lhs - rhs;
            ALU_AND: result = lhs & rhs;
            ALU_OR:  result = lhs | rhs;
            ALU_XOR: result = lhs ^ rhs;
            ALU_EQ:  result = word_t'(lhs == rhs);
            ALU_NE:  result = word_t'(lhs != rhs);
            ALU_GT:  result = word_t'(lhs > rhs);
            ALU_GE:  result = word_t'(lhs >= rhs);
            ALU_LE:  result = word_t'(lhs <= rhs);
            ALU_LT:  result = word_t'(lhs < rhs);
            ALU_SHL: result = lhs << rhs[3:0];
            ALU_SHR: result = lhs >> rhs[3:0];
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/stack_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface stack_if #(
    parameter type entry_t = logic
) ();
    import cpu_core_pkg::*;

    stack_cmd_t cmd;
    entry_t     wr_data;
    entry_t     top;
    entry_t     next;  // Word directly below the top.

    modport owner (
        output cmd,
        output wr_data,
        input  top,
        input  next
    );

    modport mem (
        input  cmd,
        input  wr_data,
        output top,
        output next
    );

    modport peek (input top, input next);

endinterface

`default_nettype wire

/* verilog/stack_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module stack_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 16
) (
    input wire logic clk,
    input wire logic nreset,
    stack_if.mem     port
);
    import cpu_core_pkg::*;

    entry_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] ptr;      // Points at the top entry.
    logic [$clog2(DEPTH)-1:0] ptr_up;
    logic [$clog2(DEPTH)-1:0] ptr_down;

    assign ptr_up   = ptr + 1'b1;
    assign ptr_down = ptr - 1'b1;

    assign port.top  = mem[ptr];
    assign port.next = mem[ptr_up];

    // The stack grows toward lower addresses and wraps around silently.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            ptr <= '0;
        end else begin
            case (port.cmd)
                STK_PUSH:        ptr <= ptr_down;
                STK_POP:         ptr <= ptr_up;
                STK_POP2:        ptr <= ptr + 2'd2;
                STK_POP_REPLACE: ptr <= ptr_up;
                default:         ptr <= ptr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (port.cmd)
            STK_PUSH: begin
                mem[ptr_down] <= port.wr_data;
            end
            STK_POP_REPLACE: begin
                mem[ptr_up] <= port.wr_data;
            end
            STK_SWAP: begin
                mem[ptr]    <= mem[ptr_up]; // Both writes land in the same edge.
                mem[ptr_up] <= mem[ptr];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire
